// ==== rob_top.f ====
+incdir+verilog
verilog/rob_pkg.sv
verilog/rob_storage.sv
verilog/retire_ctrl.sv
verilog/trap_csr.sv
verilog/rob_top.sv
verification/rob_props.sv
verification/rob_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the reorder buffer testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Iverilog \
  --top-module rob_tb -f rob_top.f -o rob_sim

# output goes to the terminal and to the search at the same time
./obj_dir/rob_sim | tee /dev/stderr | grep "Simulation completed successfully" > /dev/null

echo "run_sim: pass message found"

// ==== verification/rob_tb.sv ====
// reorder buffer testbench with stimulus, program-order model queue and watchdog
`timescale 1ns/1ps
`default_nettype none

`include "rob_macros.svh"

module rob_tb import rob_pkg::*; ();

  localparam int TEST_OPS = 140;
  localparam int WATCHDOG_CYCLES = TEST_OPS * 40 + 200;

  logic clk = 1'b0;
  logic rst_n;
  dispatch_t disp;
  wb_t wb;
  logic flush_inhibit;
  logic psel, penable, pwrite;
  logic [3:0] paddr;
  logic [`XLEN-1:0] pwdata;
  logic [`XLEN/8-1:0] pstrb;
  logic rob_full, flush, pready, pslverr;
  logic [`ROB_IDX_W-1:0] rob_id;
  logic [`PC_W-1:0] flush_pc;
  logic [`XLEN-1:0] prdata;
  retire_t retire;
  trap_t trap;

  // program-order model of the queue with the oldest entry at index 0
  rob_entry_t q[$];
  logic [`ROB_IDX_W-1:0] m_head, m_tail;
  logic [`XLEN-1:0] pl_res [`ROB_DEPTH];
  logic pl_err [`ROB_DEPTH];
  logic [4:0] pl_cause [`ROB_DEPTH];
  logic [`XLEN-1:0] nxt_res;
  logic nxt_err;
  logic [4:0] nxt_cause;
  logic m_inh;
  logic [`PC_W-1:0] m_tvec, m_epc;
  logic [4:0] m_cause;
  logic [`XLEN-1:0] m_retired;

  // expectations read by the bound assertions
  retire_t exp_ret;
  trap_t exp_trap;
  logic exp_flush, exp_present, exp_done, exp_full, exp_slverr;
  logic [`PC_W-1:0] exp_flush_pc;
  logic [`ROB_IDX_W-1:0] exp_id;
  logic [`XLEN-1:0] exp_rdata;
  logic check_failed = 1'b0;

  rob_top i_dut (.*);

  bind rob_top rob_props i_props (.*);

  always #20 clk = ~clk;

  function automatic logic outcome(rob_entry_t e);
    return e.result.data[0] ^ e.retop.invert;
  endfunction

  function automatic retire_t retire_of(rob_entry_t e);
    retire_t r;
    r.rat_valid = !e.error && !e.rd[5];
    r.rd = e.rd[4:0];
    r.value = e.forward ? {e.target, 2'b00} : e.result.data;
    r.branch = e.retop.branch;
    r.tag = e.tag;
    r.taken = outcome(e);
    r.store = !e.error && e.retop.store;
    return r;
  endfunction

  function automatic logic flush_of(rob_entry_t e);
    return e.error || e.retop.redirect || (e.retop.branch && outcome(e) != e.taken);
  endfunction

  function automatic logic [`PC_W-1:0] redirect_of(rob_entry_t e, logic [`PC_W-1:0] tv);
    if (e.error) return tv;
    if (e.forward) return e.result.data[`XLEN-1:2];
    return e.target;
  endfunction

  always @(posedge clk) begin
    rob_entry_t e;
    rob_entry_t n;
    logic fl;
    logic room;
    logic [`ROB_IDX_W-1:0] off;
    logic [`XLEN-1:0] tw;
    if (!rst_n) begin
      q.delete();
      m_head = '0;
      m_tail = '0;
      m_inh = 1'b0;
      m_tvec = '0;
      m_epc = '0;
      m_cause = '0;
      m_retired = '0;
    end else begin
      fl = 1'b0;
      // dispatch sees the occupancy from before this edge
      room = q.size() < `ROB_DEPTH;
      if (i_dut.head_valid && q.size() > 0) begin
        e = q.pop_front();
        m_head = m_head + 1'b1;
        fl = flush_of(e);
        if (e.error) begin
          m_epc = e.pc;
          m_cause = e.cause;
        end else begin
          m_retired = m_retired + 1;
        end
      end
      if (psel && penable && pwrite) begin
        tw = {m_tvec, 2'b00};
        for (int i = 0; i < `XLEN/8; i++) begin
          if (pstrb[i] && paddr == 4'h0) tw[8*i +: 8] = pwdata[8*i +: 8];
        end
        m_tvec = tw[`XLEN-1:2];
        if (paddr == 4'hC) m_retired = '0;
      end
      if (fl) begin
        // younger entries are gone
        q.delete();
        m_head = '0;
        m_tail = '0;
        m_inh = 1'b0;
      end else begin
        off = wb.id - m_head;
        if (wb.valid && !m_inh && int'(off) < q.size()) begin
          q[off].executed = 1'b1;
          q[off].error = wb.error;
          q[off].cause = wb.cause;
          q[off].result.data = wb.result;
        end
        if (disp.valid && room) begin
          n = '0;
          n.executed = disp.error || disp.retop.store;
          n.error = disp.error;
          n.cause = {3'b000, disp.cause};
          n.retop = disp.retop;
          n.pc = disp.pc;
          n.rd = disp.rd;
          n.target = disp.target;
          n.tag = disp.tag;
          n.taken = disp.taken;
          n.forward = disp.forward;
          q.push_back(n);
          pl_res[m_tail] = nxt_res;
          pl_err[m_tail] = nxt_err;
          pl_cause[m_tail] = nxt_cause;
          m_tail = m_tail + 1'b1;
        end
        m_inh = flush_inhibit;
      end
    end
    exp_full <= q.size() == `ROB_DEPTH;
    exp_id <= m_tail;
    exp_present <= q.size() > 0;
    if (q.size() > 0) begin
      exp_ret <= retire_of(q[0]);
      exp_trap <= '{valid: q[0].error, epc: q[0].pc, cause: q[0].cause};
      exp_flush <= flush_of(q[0]);
      exp_flush_pc <= redirect_of(q[0], m_tvec);
      exp_done <= q[0].executed;
    end
  end

  function automatic dispatch_t op(logic [5:0] rd, logic [`PC_W-1:0] pc);
    dispatch_t d;
    d = '0;
    d.valid = 1'b1;
    d.rd = rd;
    d.pc = pc;
    d.tag = pc[15:0];
    d.target = pc + 30'd1;
    return d;
  endfunction

  task automatic dispatch_op(input dispatch_t d, input logic [`XLEN-1:0] res,
                             input logic werr, input logic [4:0] wcause);
    @(negedge clk);
    disp = d;
    nxt_res = res;
    nxt_err = werr;
    nxt_cause = wcause;
    @(negedge clk);
    disp.valid = 1'b0;
  endtask

  // complete pending entries in random order until the model queue is empty
  task automatic drain();
    int cand[$];
    int pick;
    while (q.size() > 0) begin
      @(negedge clk);
      cand.delete();
      for (int k = 0; k < q.size(); k++) begin
        if (!q[k].executed) cand.push_back(k);
      end
      wb.valid = cand.size() > 0;
      if (cand.size() > 0) begin
        pick = cand[$urandom_range(cand.size() - 1)];
        wb.id = m_head + pick[`ROB_IDX_W-1:0];
        wb.result = pl_res[wb.id];
        wb.error = pl_err[wb.id];
        wb.cause = pl_cause[wb.id];
      end
    end
    @(negedge clk);
    wb.valid = 1'b0;
  endtask

  // wrong result in the cycle after a rename inhibit
  task automatic stale_wb();
    @(negedge clk);
    flush_inhibit = 1'b1;
    @(negedge clk);
    flush_inhibit = 1'b0;
    wb = '{valid: 1'b1, error: 1'b0, cause: 5'd0, id: m_head, result: ~pl_res[m_head]};
    @(negedge clk);
    wb.valid = 1'b0;
  endtask

  task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [`XLEN-1:0] data,
                          input logic [`XLEN/8-1:0] strb, input logic [`XLEN-1:0] expd);
    @(negedge clk);
    psel = 1'b1;
    pwrite = wr;
    paddr = addr;
    pwdata = data;
    pstrb = strb;
    exp_rdata = expd;
    exp_slverr = wr && (addr == 4'h4 || addr == 4'h8);
    @(negedge clk);
    penable = 1'b1;
    @(negedge clk);
    psel = 1'b0;
    penable = 1'b0;
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Simulation failed");
    $fatal(1, "watchdog expired before the tests finished");
  end

  always @(posedge check_failed) begin
    $display("Simulation failed");
    $fatal(1, "an assertion on the DUT outputs failed");
  end

  initial begin
    dispatch_t d;
    void'($urandom(32'h36900eb0));
    rst_n = 1'b0;
    disp = '0;
    wb = '0;
    flush_inhibit = 1'b0;
    {psel, penable, pwrite, paddr, pwdata, pstrb} = '0;
    {nxt_res, nxt_err, nxt_cause, exp_rdata, exp_slverr} = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    apb_xfer(1'b0, 4'h0, '0, '0, 32'h0);
    apb_xfer(1'b0, 4'hC, '0, '0, 32'h0);
    apb_xfer(1'b1, 4'h0, 32'hA5C3_F00C, 4'b0101, '0);
    apb_xfer(1'b0, 4'h0, '0, '0, {m_tvec, 2'b00});
    apb_xfer(1'b1, 4'h0, 32'h0000_4000, 4'b1111, '0);

    // one dispatch more than the queue holds
    for (int i = 0; i < 17; i++) begin
      dispatch_op(op(6'(i), 30'(i + 64)), $urandom, 1'b0, 5'd0);
    end
    drain();

    for (int i = 0; i < 10; i++) begin
      dispatch_op(op(6'(i + 3), 30'(i + 200)), $urandom, 1'b0, 5'd0);
    end
    stale_wb();
    drain();

    // good branch, inverted good branch, mispredicted branch
    d = op(6'h20, 30'h100);
    d.retop.branch = 1'b1;
    d.taken = 1'b1;
    dispatch_op(d, 32'h1, 1'b0, 5'd0);
    d.retop.invert = 1'b1;
    dispatch_op(d, 32'h0, 1'b0, 5'd0);
    d.retop.invert = 1'b0;
    d.taken = 1'b0;
    d.target = 30'h2345;
    dispatch_op(d, 32'h1, 1'b0, 5'd0);
    dispatch_op(op(6'd7, 30'h105), $urandom, 1'b0, 5'd0);
    drain();

    // forwarded jump with a computed target
    d = op(6'd1, 30'h300);
    d.retop.redirect = 1'b1;
    d.forward = 1'b1;
    dispatch_op(d, {30'h0ABC, 2'b00}, 1'b0, 5'd0);
    dispatch_op(op(6'd9, 30'h301), $urandom, 1'b0, 5'd0);
    drain();

    // decode error and execution error with younger entries behind each
    dispatch_op(op(6'd4, 30'h400), $urandom, 1'b0, 5'd0);
    d = op(6'd5, 30'h401);
    d.error = 1'b1;
    d.cause = 2'd2;
    dispatch_op(d, '0, 1'b0, 5'd0);
    dispatch_op(op(6'd6, 30'h402), $urandom, 1'b0, 5'd0);
    drain();
    apb_xfer(1'b0, 4'h4, '0, '0, {m_epc, 2'b00});
    apb_xfer(1'b0, 4'h8, '0, '0, {27'd0, m_cause});
    dispatch_op(op(6'd8, 30'h500), $urandom, 1'b1, 5'd13);
    dispatch_op(op(6'd9, 30'h501), $urandom, 1'b0, 5'd0);
    drain();
    apb_xfer(1'b0, 4'h4, '0, '0, {m_epc, 2'b00});
    apb_xfer(1'b0, 4'h8, '0, '0, {27'd0, m_cause});

    // store needs no completion
    d = op(6'h20, 30'h600);
    d.retop.store = 1'b1;
    dispatch_op(d, '0, 1'b0, 5'd0);
    drain();

    apb_xfer(1'b0, 4'hC, '0, '0, m_retired);
    apb_xfer(1'b1, 4'hC, 32'hFFFF_FFFF, 4'b1111, '0);
    apb_xfer(1'b0, 4'hC, '0, '0, 32'h0);
    apb_xfer(1'b1, 4'h4, 32'h1234, 4'b1111, '0);

    repeat (4) @(posedge clk);
    if (check_failed) begin
      $display("Simulation failed");
      $fatal(1, "a check failed during the run");
    end else begin
      $display("Simulation completed successfully");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== verification/rob_props.sv ====
// concurrent assertions on retirement, flush, queue state and apb reads
`timescale 1ns/1ps
`default_nettype none

`include "rob_macros.svh"

module rob_props import rob_pkg::*; (
  input wire logic                  clk,
  input wire logic                  rst_n,
  input wire logic                  head_valid,
  input wire logic                  flush,
  input wire logic [`PC_W-1:0]      flush_pc,
  input wire retire_t               retire,
  input wire trap_t                 trap,
  input wire logic                  rob_full,
  input wire logic [`ROB_IDX_W-1:0] rob_id,
  input wire logic                  psel,
  input wire logic                  penable,
  input wire logic                  pwrite,
  input wire logic [`XLEN-1:0]      prdata,
  input wire logic                  pready,
  input wire logic                  pslverr
);

  // only a completed entry that the model holds may retire
  a_retire_ready: assert property (@(posedge clk) disable iff (!rst_n)
    head_valid |-> rob_tb.exp_present && rob_tb.exp_done)
    else begin
      $error("** Error at %0t: retirement without a completed entry", $time);
      rob_tb.check_failed = 1'b1;
    end

  a_retire_fields: assert property (@(posedge clk) disable iff (!rst_n)
    head_valid |-> retire == rob_tb.exp_ret && trap == rob_tb.exp_trap)
    else begin
      $error("** Error at %0t: retire or trap fields differ from model", $time);
      rob_tb.check_failed = 1'b1;
    end

  a_flush: assert property (@(posedge clk) disable iff (!rst_n)
    head_valid |-> flush == rob_tb.exp_flush && flush_pc == rob_tb.exp_flush_pc)
    else begin
      $error("** Error at %0t: flush or flush_pc differs from model", $time);
      rob_tb.check_failed = 1'b1;
    end

  a_queue: assert property (@(posedge clk) disable iff (!rst_n)
    rob_full == rob_tb.exp_full && rob_id == rob_tb.exp_id)
    else begin
      $error("** Error at %0t: rob_full or rob_id differs from model", $time);
      rob_tb.check_failed = 1'b1;
    end

  a_apb: assert property (@(posedge clk) disable iff (!rst_n)
    psel && penable |-> pready && pslverr == rob_tb.exp_slverr
      && (pwrite || prdata == rob_tb.exp_rdata))
    else begin
      $error("** Error at %0t: apb response differs from model", $time);
      rob_tb.check_failed = 1'b1;
    end

endmodule

`default_nettype wire

// ==== verilog/rob_top.sv ====
// reorder buffer top: storage, retire decode and trap csr
`timescale 1ns/1ps
`default_nettype none

`include "rob_macros.svh"

module rob_top import rob_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  // decode
  input  dispatch_t             disp,
  output logic                  rob_full,
  output logic [`ROB_IDX_W-1:0] rob_id,
  // rename
  input  logic                  flush_inhibit,
  // execution units
  input  wb_t                   wb,
  // fetch, rat, predictor and lsq
  output logic                  flush,
  output logic [`PC_W-1:0]      flush_pc,
  output retire_t               retire,
  output trap_t                 trap,
  // apb
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [3:0]            paddr,
  input  logic [`XLEN-1:0]      pwdata,
  input  logic [`XLEN/8-1:0]    pstrb,
  output logic [`XLEN-1:0]      prdata,
  output logic                  pready,
  output logic                  pslverr
);

  rob_entry_t       head;
  logic             head_valid;
  logic [`PC_W-1:0] tvec;

  rob_storage i_storage (
    .clk           (clk),
    .rst_n         (rst_n),
    .disp          (disp),
    .wb            (wb),
    .flush_inhibit (flush_inhibit),
    .flush         (flush),
    .rob_full      (rob_full),
    .rob_id        (rob_id),
    .head          (head),
    .head_valid    (head_valid)
  );

  retire_ctrl i_retire (
    .head       (head),
    .head_valid (head_valid),
    .tvec       (tvec),
    .flush      (flush),
    .flush_pc   (flush_pc),
    .retire     (retire),
    .trap       (trap)
  );

  trap_csr i_csr (
    .clk        (clk),
    .rst_n      (rst_n),
    .trap       (trap),
    .head_valid (head_valid),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .pstrb      (pstrb),
    .tvec       (tvec),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr)
  );

endmodule

`default_nettype wire

// ==== verilog/trap_csr.sv ====
// apb trap csr block: trap vector, exception pc, cause and retire counter
`timescale 1ns/1ps
`default_nettype none

`include "rob_macros.svh"

module trap_csr import rob_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  trap_t                trap,
  input  logic                 head_valid,
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  logic [3:0]           paddr,
  input  logic [`XLEN-1:0]     pwdata,
  input  logic [`XLEN/8-1:0]   pstrb,
  output logic [`PC_W-1:0]     tvec,
  output logic [`XLEN-1:0]     prdata,
  output logic                 pready,
  output logic                 pslverr
);

  localparam logic [3:0] ADDR_TVEC    = 4'h0;
  localparam logic [3:0] ADDR_EPC     = 4'h4;
  localparam logic [3:0] ADDR_CAUSE   = 4'h8;
  localparam logic [3:0] ADDR_RETIRED = 4'hC;

  logic [`PC_W-1:0] tvec_q;
  logic [`PC_W-1:0] epc_q;
  logic [4:0]       cause_q;
  logic [`XLEN-1:0] retired_q;
  logic [`XLEN-1:0] tvec_wdata;
  logic             apb_wr;

  // no wait states
  assign pready = psel & penable;
  assign apb_wr = psel & penable & pwrite;

  // merge strobed bytes over the current vector
  always_comb begin
    tvec_wdata = {tvec_q, 2'b00};
    for (int i = 0; i < `XLEN/8; i++) begin
      if (pstrb[i]) begin
        tvec_wdata[8*i +: 8] = pwdata[8*i +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tvec_q <= '0;
    end else if (apb_wr && paddr == ADDR_TVEC) begin
      tvec_q <= tvec_wdata[`XLEN-1:2];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      epc_q   <= '0;
      cause_q <= '0;
    end else if (trap.valid) begin
      epc_q   <= trap.epc;
      cause_q <= trap.cause;
    end
  end

  // software write clears, otherwise count clean retirements
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      retired_q <= '0;
    end else if (apb_wr && paddr == ADDR_RETIRED) begin
      retired_q <= '0;
    end else if (head_valid && !trap.valid) begin
      retired_q <= retired_q + 1'b1;
    end
  end

  assign tvec = tvec_q;

  always_comb begin
    case (paddr)
      ADDR_TVEC:    prdata = {tvec_q, 2'b00};
      ADDR_EPC:     prdata = {epc_q, 2'b00};
      ADDR_CAUSE:   prdata = {{(`XLEN-5){1'b0}}, cause_q};
      ADDR_RETIRED: prdata = retired_q;
      default:      prdata = '0;
    endcase
  end

  // epc and cause are read only
  assign pslverr = apb_wr & ((paddr == ADDR_EPC) | (paddr == ADDR_CAUSE));

endmodule

`default_nettype wire

// ==== verilog/retire_ctrl.sv ====
// retire decode: flush, redirect pc, rat write, predictor update, store commit, trap
`timescale 1ns/1ps
`default_nettype none

`include "rob_macros.svh"

module retire_ctrl import rob_pkg::*; (
  input  rob_entry_t       head,
  input  logic             head_valid,
  input  logic [`PC_W-1:0] tvec,
  output logic             flush,
  output logic [`PC_W-1:0] flush_pc,
  output retire_t          retire,
  output trap_t            trap
);

  logic br_taken;
  logic exc;
  logic mispred;

  // outcome before inversion lives in bit 0 of the result
  assign br_taken = head.result.br.cond ^ head.retop.invert;

  assign exc = head_valid & head.error;

  // forced redirect or a branch that went the other way
  assign mispred = head_valid &
                   (head.retop.redirect | (head.retop.branch & (br_taken ^ head.taken)));

  assign flush = exc | mispred;

  always_comb begin
    if (head.error) begin
      flush_pc = tvec;
    end else if (head.forward) begin
      // computed jump target from the execution unit
      flush_pc = head.result.br.pc;
    end else begin
      flush_pc = head.target;
    end
  end

  // rd[5] set means no destination register
  assign retire.rat_valid = head_valid & ~head.error & ~head.rd[5];
  assign retire.rd        = head.rd[4:0];

  // forwarded jumps write the link address
  assign retire.value = head.forward ? {head.target, 2'b00} : head.result.data;

  // predictor update
  assign retire.branch = head_valid & head.retop.branch;
  assign retire.tag    = head.tag;
  assign retire.taken  = br_taken;

  // store commit to the lsq
  assign retire.store = head_valid & ~head.error & head.retop.store;

  // trap report
  assign trap.valid = exc;
  assign trap.epc   = head.pc;
  assign trap.cause = head.cause;

endmodule

`default_nettype wire

// ==== verilog/rob_storage.sv ====
// reorder buffer entry storage with head/tail pointers and registered head read
`timescale 1ns/1ps
`default_nettype none

`include "rob_macros.svh"

module rob_storage import rob_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  dispatch_t             disp,
  input  wb_t                   wb,
  input  logic                  flush_inhibit,
  input  logic                  flush,
  output logic                  rob_full,
  output logic [`ROB_IDX_W-1:0] rob_id,
  output rob_entry_t            head,
  output logic                  head_valid
);

  rob_entry_t mem [`ROB_DEPTH];

  // msb of each pointer is the wrap phase
  logic [`ROB_IDX_W:0]   head_ptr;
  logic [`ROB_IDX_W:0]   tail_ptr;
  logic [`ROB_IDX_W:0]   head_ptr_nxt;
  logic [`ROB_IDX_W:0]   rd_ptr;
  logic [`ROB_IDX_W-1:0] tail_idx;
  logic [`ROB_IDX_W-1:0] rd_idx;
  logic                  same_idx;
  logic                  rob_empty;
  logic                  rd_present;
  logic                  disp_beat;
  logic                  wb_beat;
  logic                  inhibit_q;

  assign tail_idx  = tail_ptr[`ROB_IDX_W-1:0];
  assign same_idx  = head_ptr[`ROB_IDX_W-1:0] == tail_idx;
  assign rob_full  = same_idx & (head_ptr[`ROB_IDX_W] != tail_ptr[`ROB_IDX_W]);
  assign rob_empty = same_idx & (head_ptr[`ROB_IDX_W] == tail_ptr[`ROB_IDX_W]);
  assign rob_id    = tail_idx;

  assign disp_beat = disp.valid & ~rob_full;
  // completions right after a rename inhibit are stale
  assign wb_beat   = wb.valid & ~inhibit_q;

  // look one entry ahead while the head is retiring
  assign head_ptr_nxt = head_ptr + 1'b1;
  assign rd_ptr       = head_valid ? head_ptr_nxt : head_ptr;
  assign rd_idx       = rd_ptr[`ROB_IDX_W-1:0];
  assign rd_present   = head_valid ? (head_ptr_nxt != tail_ptr) : ~rob_empty;

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      head_ptr <= '0;
    end else if (head_valid) begin
      head_ptr <= head_ptr_nxt;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      tail_ptr <= '0;
    end else if (disp_beat) begin
      tail_ptr <= tail_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      inhibit_q <= 1'b0;
    end else begin
      inhibit_q <= flush_inhibit;
    end
  end

  // entry writes, writeback last so it wins on a shared index
  always_ff @(posedge clk) begin
    if (disp_beat) begin
      // decode errors and stores need no completion
      mem[tail_idx].executed    <= disp.error | disp.retop.store;
      mem[tail_idx].error       <= disp.error;
      mem[tail_idx].cause       <= {3'b000, disp.cause};
      mem[tail_idx].retop       <= disp.retop;
      mem[tail_idx].pc          <= disp.pc;
      mem[tail_idx].rd          <= disp.rd;
      mem[tail_idx].result.data <= '0;
      mem[tail_idx].target      <= disp.target;
      mem[tail_idx].tag         <= disp.tag;
      mem[tail_idx].taken       <= disp.taken;
      mem[tail_idx].forward     <= disp.forward;
    end
    if (wb_beat) begin
      mem[wb.id].executed    <= 1'b1;
      mem[wb.id].error       <= wb.error;
      mem[wb.id].cause       <= wb.cause;
      mem[wb.id].result.data <= wb.result;
    end
  end

  // registered head read
  always_ff @(posedge clk) begin
    head <= mem[rd_idx];
  end

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      head_valid <= 1'b0;
    end else begin
      head_valid <= mem[rd_idx].executed & rd_present;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/rob_pkg.sv ====
// dispatch, writeback, entry, retire and trap records plus the result union
`default_nettype none

package rob_pkg;

  `include "rob_macros.svh"

  // retire opcode, spare bits kept for future use
  typedef struct packed {
    logic       branch;
    logic       invert;
    logic       redirect;
    logic       store;
    logic [2:0] spare;
  } retop_t;

  // one decoded instruction from decode
  typedef struct packed {
    logic                 valid;
    logic                 error;
    logic [1:0]           cause;
    retop_t               retop;
    logic [`PC_W-1:0]     pc;
    logic [5:0]           rd;
    logic [`BP_TAG_W-1:0] tag;
    logic                 taken;
    logic                 forward;
    logic [`PC_W-1:0]     target;
  } dispatch_t;

  // one completion from the execution units
  typedef struct packed {
    logic                  valid;
    logic                  error;
    logic [4:0]            cause;
    logic [`ROB_IDX_W-1:0] id;
    logic [`XLEN-1:0]      result;
  } wb_t;

  // branch reading of the result word
  typedef struct packed {
    logic [`PC_W-1:0] pc;
    logic             spare;
    logic             cond;
  } br_view_t;

  typedef union packed {
    logic [`XLEN-1:0] data;
    br_view_t         br;
  } result_u;

  typedef struct packed {
    logic                 executed;
    logic                 error;
    logic [4:0]           cause;
    retop_t               retop;
    logic [`PC_W-1:0]     pc;
    logic [5:0]           rd;
    result_u              result;
    logic [`PC_W-1:0]     target;
    logic [`BP_TAG_W-1:0] tag;
    logic                 taken;
    logic                 forward;
  } rob_entry_t;

  // rat, predictor and lsq side of retirement
  typedef struct packed {
    logic                 rat_valid;
    logic [4:0]           rd;
    logic [`XLEN-1:0]     value;
    logic                 branch;
    logic [`BP_TAG_W-1:0] tag;
    logic                 taken;
    logic                 store;
  } retire_t;

  typedef struct packed {
    logic             valid;
    logic [`PC_W-1:0] epc;
    logic [4:0]       cause;
  } trap_t;

endpackage

`default_nettype wire

// ==== verilog/rob_macros.svh ====
// queue index, pc and data width defines for the reorder buffer
`ifndef ROB_MACROS_SVH
`define ROB_MACROS_SVH

// queue index width, 2 to 7 supported
`define ROB_IDX_W 4

// number of queue entries
`define ROB_DEPTH (1 << `ROB_IDX_W)

// data word width
`define XLEN 32

// word-aligned pc, bits 31 to 2 of the byte address
`define PC_W 30

// predictor tag width
`define BP_TAG_W 16

`endif
